// File: hw/rv32i_pkg.sv
package rv32i_pkg;

    typedef logic [31:0] rv32i_word;
    typedef logic [4:0]  rv32i_reg;

    // ALU operations. Pass-b forwards operand B for LUI.
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10
    } alu_op_t;

    typedef enum logic [1:0] {
        src_a_rs1  = 2'd0,
        src_a_pc   = 2'd1,
        src_a_zero = 2'd2
    } src_a_sel_t;

    typedef enum logic [2:0] {
        imm_i = 3'd0,
        imm_s = 3'd1,
        imm_b = 3'd2,
        imm_u = 3'd3,
        imm_j = 3'd4
    } imm_sel_t;

    // Control word of 21 bits.
    typedef struct packed {
        alu_op_t    alu_op;
        src_a_sel_t src_a_sel;
        logic       use_imm;   // Operand B is the immediate.
        imm_sel_t   imm_sel;
        rv32i_reg   rs1;
        rv32i_reg   rs2;
        logic       reg_write;
    } ctrl_word_t;

    localparam logic [6:0] op_reg   = 7'b0110011;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000; // Sub and sra.

endpackage

// File: hw/control_word.sv
`timescale 1ns/1ps

module control_word
    import rv32i_pkg::*;
(
    input  rv32i_word  instr,
    output ctrl_word_t ctrl_wd,
    output rv32i_reg   dest,
    output logic       illegal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7_ok;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign dest   = instr[11:7];

    // Shared funct3 mapping. Alt selects sub or sra.
    function automatic alu_op_t alu_from_funct(logic [2:0] f3, logic alt);
        alu_op_t op;
        case (f3)
            f3_add_sub: op = alt ? alu_sub : alu_add;
            f3_sll:     op = alu_sll;
            f3_slt:     op = alu_slt;
            f3_sltu:    op = alu_sltu;
            f3_xor:     op = alu_xor;
            f3_srl_sra: op = alt ? alu_sra : alu_srl;
            f3_or:      op = alu_or;
            default:    op = alu_and;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl_wd.alu_op    = alu_add;
        ctrl_wd.src_a_sel = src_a_rs1;
        ctrl_wd.use_imm   = 1'b0;
        ctrl_wd.imm_sel   = imm_i;
        ctrl_wd.rs1       = '0;
        ctrl_wd.rs2       = '0;
        ctrl_wd.reg_write = 1'b0;
        f7_ok             = 1'b1;
        illegal           = 1'b0;

        case (opcode)
            op_reg: begin
                ctrl_wd.rs1       = instr[19:15];
                ctrl_wd.rs2       = instr[24:20];
                ctrl_wd.reg_write = 1'b1;
                ctrl_wd.alu_op    = alu_from_funct(funct3, funct7 == f7_alt);
                // Only add and srl have an alternate form.
                f7_ok = (funct7 == f7_base) ||
                        (funct7 == f7_alt &&
                         (funct3 == f3_add_sub || funct3 == f3_srl_sra));
            end
            op_imm: begin
                ctrl_wd.rs1       = instr[19:15];
                ctrl_wd.use_imm   = 1'b1;
                ctrl_wd.reg_write = 1'b1;
                ctrl_wd.alu_op    = alu_from_funct(funct3,
                                        funct3 == f3_srl_sra && funct7 == f7_alt);
                if (funct3 == f3_sll)
                    f7_ok = (funct7 == f7_base);
                else if (funct3 == f3_srl_sra)
                    f7_ok = (funct7 == f7_base) || (funct7 == f7_alt);
            end
            op_lui: begin
                ctrl_wd.src_a_sel = src_a_zero;
                ctrl_wd.use_imm   = 1'b1;
                ctrl_wd.imm_sel   = imm_u;
                ctrl_wd.alu_op    = alu_pass_b;
                ctrl_wd.reg_write = 1'b1;
            end
            op_auipc: begin
                ctrl_wd.src_a_sel = src_a_pc; // Pc plus u immediate.
                ctrl_wd.use_imm   = 1'b1;
                ctrl_wd.imm_sel   = imm_u;
                ctrl_wd.reg_write = 1'b1;
            end
            default: illegal = 1'b1;
        endcase

        if (!f7_ok)
            illegal = 1'b1;
        if (illegal)
            ctrl_wd.reg_write = 1'b0; // Illegal writes nothing.
    end

endmodule

// File: hw/regfile.sv
`timescale 1ns/1ps

module regfile
    import rv32i_pkg::*;
#(
    parameter int num_regs = 32
)
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      load,
    input  rv32i_word in,
    input  rv32i_reg  src_a,
    input  rv32i_reg  src_b,
    input  rv32i_reg  dest,
    output rv32i_word reg_a,
    output rv32i_word reg_b
);

    rv32i_word regs [1:num_regs-1]; // x0 has no storage.

    // Zero for x0 and out-of-range indices. Same-cycle writes bypass.
    function automatic rv32i_word read_port(rv32i_reg idx);
        rv32i_word value;
        value = '0;
        if (idx != '0 && int'(idx) < num_regs) begin
            if (load && dest == idx)
                value = in;
            else
                value = regs[idx];
        end
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < num_regs; i++)
                regs[i] <= '0;
        end else if (load && dest != '0 && int'(dest) < num_regs) begin
            regs[dest] <= in;
        end
    end

    always_comb begin
        reg_a = read_port(src_a);
        reg_b = read_port(src_b);
    end

    a_x0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (src_a == '0 || src_b == '0) |->
            ((src_a != '0 || reg_a == '0) && (src_b != '0 || reg_b == '0)));

endmodule

// File: hw/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
)
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk) begin
        if (!rst_n)
            out_valid <= 1'b0;
        else
            out_valid <= in_valid;
    end

    // Payload moves every cycle.
    always_ff @(posedge clk) begin
        out_data <= in_data;
    end

    a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(out_valid));

endmodule

// File: hw/i_decode.sv
`timescale 1ns/1ps

module i_decode
    import rv32i_pkg::*;
#(
    parameter int num_regs = 32
)
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       id_valid,
    input  rv32i_word  id_instr,
    input  rv32i_word  id_pc,
    input  logic       load_regfile,
    input  rv32i_reg   rd_wb,       // Write index from writeback.
    input  rv32i_word  regfile_in,
    output ctrl_word_t ctrl_wd,
    output rv32i_word  rs1_data,
    output rv32i_word  rs2_data,
    output rv32i_word  imm,
    output rv32i_reg   rd,
    output logic       illegal
);

    rv32i_word i_imm, s_imm, b_imm, u_imm, j_imm;
    logic      dec_illegal;

    // Sign-extended immediates.
    assign i_imm = {{21{id_instr[31]}}, id_instr[30:20]};
    assign s_imm = {{21{id_instr[31]}}, id_instr[30:25], id_instr[11:7]};
    assign b_imm = {{20{id_instr[31]}}, id_instr[7], id_instr[30:25],
                    id_instr[11:8], 1'b0};
    assign u_imm = {id_instr[31:12], 12'h000};
    assign j_imm = {{12{id_instr[31]}}, id_instr[19:12], id_instr[20],
                    id_instr[30:21], 1'b0};

    always_comb begin
        case (ctrl_wd.imm_sel)
            imm_s:   imm = s_imm;
            imm_b:   imm = b_imm;
            imm_u:   imm = u_imm;
            imm_j:   imm = j_imm;
            default: imm = i_imm;
        endcase
    end

    assign illegal = id_valid && dec_illegal; // Only a real instruction is flagged.

    control_word u_control_word (
        .instr   (id_instr),
        .ctrl_wd (ctrl_wd),
        .dest    (rd),
        .illegal (dec_illegal)
    );

    regfile #(
        .num_regs (num_regs)
    ) u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (load_regfile),
        .in    (regfile_in),
        .src_a (ctrl_wd.rs1),
        .src_b (ctrl_wd.rs2),
        .dest  (rd_wb),
        .reg_a (rs1_data),
        .reg_b (rs2_data)
    );

    a_illegal_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        id_valid |-> !(illegal && ctrl_wd.reg_write));

    a_pc_known: assert property (@(posedge clk) disable iff (!rst_n)
        id_valid |-> !$isunknown(id_pc));

endmodule

// File: hw/alu_execute.sv
`timescale 1ns/1ps

module alu_execute
    import rv32i_pkg::*;
(
    input  logic       ex_valid,
    input  ctrl_word_t ctrl_wd,
    input  rv32i_word  rs1_data,
    input  rv32i_word  rs2_data,
    input  rv32i_word  imm,
    input  rv32i_word  pc,
    input  logic       fwd_valid,   // Writeback stage is writing.
    input  rv32i_reg   fwd_rd,
    input  rv32i_word  fwd_data,
    output rv32i_word  result
);

    logic      fwd_a, fwd_b;
    rv32i_word src1, src2;
    rv32i_word op_a, op_b;
    logic [4:0] shamt;

    // Forward from writeback on a nonzero index match.
    assign fwd_a = ex_valid && fwd_valid && ctrl_wd.rs1 != '0 && fwd_rd == ctrl_wd.rs1;
    assign fwd_b = ex_valid && fwd_valid && ctrl_wd.rs2 != '0 && fwd_rd == ctrl_wd.rs2;

    assign src1 = fwd_a ? fwd_data : rs1_data;
    assign src2 = fwd_b ? fwd_data : rs2_data;

    always_comb begin
        case (ctrl_wd.src_a_sel)
            src_a_pc:   op_a = pc;
            src_a_zero: op_a = '0;
            default:    op_a = src1;
        endcase
    end

    assign op_b  = ctrl_wd.use_imm ? imm : src2;
    assign shamt = op_b[4:0]; // Low five bits only.

    always_comb begin
        case (ctrl_wd.alu_op)
            alu_add:    result = op_a + op_b;
            alu_sub:    result = op_a - op_b;
            alu_sll:    result = op_a << shamt;
            alu_slt:    result = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu:   result = {31'b0, op_a < op_b};
            alu_xor:    result = op_a ^ op_b;
            alu_srl:    result = op_a >> shamt;
            alu_sra:    result = $unsigned($signed(op_a) >>> shamt);
            alu_or:     result = op_a | op_b;
            alu_and:    result = op_a & op_b;
            alu_pass_b: result = op_b;
            default:    result = '0;
        endcase
    end

endmodule

// File: hw/rv32i_pipe_top.sv
`timescale 1ns/1ps

module rv32i_pipe_top
    import rv32i_pkg::*;
#(
    parameter int num_regs = 32
)
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      instr_valid,
    input  rv32i_word instr,
    input  rv32i_word pc,
    output logic      wb_valid,
    output rv32i_reg  wb_rd,
    output rv32i_word wb_data,
    output rv32i_word wb_pc,
    output logic      illegal_instr
);

    typedef struct packed {
        rv32i_word instr;
        rv32i_word pc;
    } if_id_t;

    typedef struct packed {
        ctrl_word_t ctrl_wd;
        rv32i_word  rs1_data;
        rv32i_word  rs2_data;
        rv32i_word  imm;
        rv32i_reg   rd;
        logic       illegal;
        rv32i_word  pc;
    } id_ex_t;

    typedef struct packed {
        rv32i_word result;
        rv32i_reg  rd;
        logic      reg_write;
        logic      illegal;
        rv32i_word pc;
    } ex_wb_t;

    logic      if_id_valid, id_ex_valid, ex_wb_valid;
    if_id_t    if_id_in, if_id_out;
    id_ex_t    id_ex_in, id_ex_out;
    ex_wb_t    ex_wb_in, ex_wb_out;
    logic      wb_we;

    assign if_id_in = '{instr: instr, pc: pc};

    stage_reg #(.payload_t(if_id_t)) u_if_id (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (instr_valid),
        .in_data   (if_id_in),
        .out_valid (if_id_valid),
        .out_data  (if_id_out)
    );

    i_decode #(
        .num_regs (num_regs)
    ) u_i_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .id_valid     (if_id_valid),
        .id_instr     (if_id_out.instr),
        .id_pc        (if_id_out.pc),
        .load_regfile (wb_we),
        .rd_wb        (wb_rd),
        .regfile_in   (wb_data),
        .ctrl_wd      (id_ex_in.ctrl_wd),
        .rs1_data     (id_ex_in.rs1_data),
        .rs2_data     (id_ex_in.rs2_data),
        .imm          (id_ex_in.imm),
        .rd           (id_ex_in.rd),
        .illegal      (id_ex_in.illegal)
    );

    assign id_ex_in.pc = if_id_out.pc;

    stage_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (if_id_valid),
        .in_data   (id_ex_in),
        .out_valid (id_ex_valid),
        .out_data  (id_ex_out)
    );

    alu_execute u_alu_execute (
        .ex_valid  (id_ex_valid),
        .ctrl_wd   (id_ex_out.ctrl_wd),
        .rs1_data  (id_ex_out.rs1_data),
        .rs2_data  (id_ex_out.rs2_data),
        .imm       (id_ex_out.imm),
        .pc        (id_ex_out.pc),
        .fwd_valid (wb_we),
        .fwd_rd    (wb_rd),
        .fwd_data  (wb_data),
        .result    (ex_wb_in.result)
    );

    assign ex_wb_in.rd        = id_ex_out.rd;
    assign ex_wb_in.reg_write = id_ex_out.ctrl_wd.reg_write;
    assign ex_wb_in.illegal   = id_ex_out.illegal;
    assign ex_wb_in.pc        = id_ex_out.pc;

    stage_reg #(.payload_t(ex_wb_t)) u_ex_wb (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (id_ex_valid),
        .in_data   (ex_wb_in),
        .out_valid (ex_wb_valid),
        .out_data  (ex_wb_out)
    );

    // Writeback drives the regfile and the forward path.
    assign wb_we = ex_wb_valid && ex_wb_out.reg_write && !ex_wb_out.illegal;

    assign wb_valid      = ex_wb_valid && !ex_wb_out.illegal;
    assign illegal_instr = ex_wb_valid && ex_wb_out.illegal; // One pulse per instruction.
    assign wb_rd         = ex_wb_out.rd;
    assign wb_data       = ex_wb_out.result;
    assign wb_pc         = ex_wb_out.pc;

endmodule

// File: dv/rv32i_pipe_tb.sv
`timescale 1ns/1ps

module rv32i_pipe_tb
    import rv32i_pkg::*;
();

    localparam int reset_cycles = 2;
    localparam int n_lui   = 31;
    localparam int n_imm   = 48;
    localparam int n_reg   = 48;
    localparam int n_auipc = 8;
    localparam int n_dep   = 12; // Four instructions each.
    localparam int n_ill   = 6;  // Two instructions each.
    localparam int n_slots = reset_cycles + 3 + n_lui + n_imm + n_reg + n_auipc
                             + 4 * n_dep + 4 + 2 * n_ill + 6;
    localparam int max_cycles = n_slots + 20;

    logic      clk, rst_n, instr_valid;
    rv32i_word instr, pc;
    logic      wb_valid, illegal_instr;
    rv32i_reg  wb_rd;
    rv32i_word wb_data, wb_pc;

    // Expected reports in program order.
    logic      exp_illegal [0:255];
    rv32i_reg  exp_rd      [0:255];
    rv32i_word exp_data    [0:255];
    rv32i_word exp_pc      [0:255];
    int        exp_cycle   [0:255];
    string     exp_test    [0:255];
    logic [7:0] wr_idx, rd_idx;

    logic      head_illegal;
    rv32i_reg  head_rd;
    rv32i_word head_data, head_pc;
    int        head_cycle;

    int        cycle;
    logic [15:0] lfsr;
    rv32i_word pc_next;
    rv32i_word ref_regs [0:31];

    rv32i_pipe_top #(
        .num_regs (32)
    ) DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .pc            (pc),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .wb_pc         (wb_pc),
        .illegal_instr (illegal_instr)
    );

    always #20 clk = ~clk;

    assign head_illegal = exp_illegal[rd_idx];
    assign head_rd      = exp_rd[rd_idx];
    assign head_data    = exp_data[rd_idx];
    assign head_pc      = exp_pc[rd_idx];
    assign head_cycle   = exp_cycle[rd_idx];

    task automatic report_mismatch(string test, string field, rv32i_word exp_v, rv32i_word act_v);
        $display("FAIL %s %s expected %h actual %h", test, field, exp_v, act_v);
        $display("Checks failed");
        $fatal(1, "mismatch on %s", field);
    endtask

    task automatic report_error(string msg);
        $display("ERROR %s", msg);
        $display("Checks failed");
        $fatal(1, "%s", msg);
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (rst_n && (wb_valid || illegal_instr))
            rd_idx <= rd_idx + 1; // Pop the head.
        if (cycle >= max_cycles)
            report_error("run exceeded its cycle limit");
    end

    a_quiet_in_reset: assert property (@(posedge clk)
        (!rst_n && cycle > 0) |-> !(wb_valid || illegal_instr))
        else report_error("report seen while reset was asserted");

    a_report_pending: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_valid || illegal_instr) |-> rd_idx != wr_idx)
        else report_error("report arrived with no instruction pending");

    a_kind: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_valid || illegal_instr) |->
            (wb_valid == !head_illegal && illegal_instr == head_illegal))
        else report_mismatch(exp_test[$sampled(rd_idx)], "wb_valid/illegal_instr",
                             {30'b0, !$sampled(head_illegal), $sampled(head_illegal)},
                             {30'b0, $sampled(wb_valid), $sampled(illegal_instr)});

    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_valid || illegal_instr) |-> cycle == head_cycle)
        else report_mismatch(exp_test[$sampled(rd_idx)], "report cycle",
                             $sampled(head_cycle), $sampled(cycle));

    a_pc: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_valid || illegal_instr) |-> wb_pc == head_pc)
        else report_mismatch(exp_test[$sampled(rd_idx)], "wb_pc",
                             $sampled(head_pc), $sampled(wb_pc));

    a_rd: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> wb_rd == head_rd)
        else report_mismatch(exp_test[$sampled(rd_idx)], "wb_rd",
                             {27'b0, $sampled(head_rd)}, {27'b0, $sampled(wb_rd)});

    a_data: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> wb_data == head_data)
        else report_mismatch(exp_test[$sampled(rd_idx)], "wb_data",
                             $sampled(head_data), $sampled(wb_data));

    // Taps 16, 14, 13, 11.
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic rv32i_word rand_bits(int n);
        rv32i_word v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic rv32i_reg rand_reg();
        rv32i_word r;
        r = rand_bits(5);
        return (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
    endfunction

    function automatic rv32i_word enc_r(logic [6:0] f7, rv32i_reg rs2, rv32i_reg rs1,
                                        logic [2:0] f3, rv32i_reg rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic rv32i_word enc_i(logic [11:0] imm, rv32i_reg rs1, logic [2:0] f3,
                                        rv32i_reg rd);
        return {imm, rs1, f3, rd, op_imm};
    endfunction

    function automatic rv32i_word enc_u(logic [6:0] opc, logic [19:0] imm, rv32i_reg rd);
        return {imm, rd, opc};
    endfunction

    // ISA semantics of the funct3 operations.
    function automatic rv32i_word alu_ref(logic [2:0] f3, logic alt, rv32i_word a, rv32i_word b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    if (alt) return $signed(a) >>> b[4:0]; else return a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // Strobes one instruction and records its expected report.
    task automatic issue(string name, rv32i_word word);
        rv32i_word  a, b, res;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       bad;
        @(negedge clk);
        a   = ref_regs[word[19:15]];
        b   = ref_regs[word[24:20]];
        f3  = word[14:12];
        f7  = word[31:25];
        res = '0;
        bad = 1'b0;
        case (word[6:0])
            op_reg: begin
                bad = !(f7 == f7_base ||
                        (f7 == f7_alt && (f3 == f3_add_sub || f3 == f3_srl_sra)));
                res = alu_ref(f3, f7 == f7_alt, a, b);
            end
            op_imm: begin
                bad = (f3 == f3_sll && f7 != f7_base) ||
                      (f3 == f3_srl_sra && f7 != f7_base && f7 != f7_alt);
                res = alu_ref(f3, f3 == f3_srl_sra && f7 == f7_alt, a,
                              {{20{word[31]}}, word[31:20]});
            end
            op_lui:   res = {word[31:12], 12'h000};
            op_auipc: res = pc_next + {word[31:12], 12'h000};
            default:  bad = 1'b1;
        endcase
        exp_illegal[wr_idx] = bad;
        exp_rd[wr_idx]      = word[11:7];
        exp_data[wr_idx]    = res;
        exp_pc[wr_idx]      = pc_next;
        exp_cycle[wr_idx]   = cycle + 3; // Report three cycles after the strobe.
        exp_test[wr_idx]    = name;
        wr_idx              = wr_idx + 1;
        if (!bad && word[11:7] != 5'd0)
            ref_regs[word[11:7]] = res;
        instr_valid = 1'b1;
        instr       = word;
        pc          = pc_next;
        pc_next     = pc_next + 4;
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(negedge clk);
            instr_valid = 1'b0;
            instr       = rand_bits(32); // Junk on an idle bus.
        end
    endtask

    initial begin
        int         k;
        rv32i_word  r, word;
        logic [2:0] f3;
        logic [6:0] f7;
        rv32i_reg   ra, rb, rc, rd;
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        cycle       = 0;
        wr_idx      = '0;
        rd_idx      = '0;
        lfsr        = 16'd14796;
        pc_next     = 32'h0000_0100;
        for (int i = 0; i < 32; i++)
            ref_regs[i] = '0;
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
        idle(3);

        for (k = 1; k <= n_lui; k++) begin // Random upper bits into every register.
            r = rand_bits(20);
            issue("lui", enc_u(op_lui, r[19:0], 5'(k)));
        end

        repeat (n_imm) begin
            r  = rand_bits(32);
            f3 = r[14:12];
            f7 = r[31:25];
            if (f3 == f3_sll)
                f7 = f7_base;
            else if (f3 == f3_srl_sra)
                f7 = r[31] ? f7_alt : f7_base;
            issue("reg_imm", enc_i({f7, r[24:20]}, r[19:15], f3, rand_reg()));
        end

        repeat (n_reg) begin
            r  = rand_bits(32);
            f3 = r[14:12];
            f7 = (r[31] && (f3 == f3_add_sub || f3 == f3_srl_sra)) ? f7_alt : f7_base;
            issue("reg_reg", enc_r(f7, r[24:20], r[19:15], f3, rand_reg()));
        end

        repeat (n_auipc) begin
            r = rand_bits(20);
            issue("auipc", enc_u(op_auipc, r[19:0], rand_reg()));
        end

        // Dependent chains at distances one, two and three.
        repeat (n_dep) begin
            ra = rand_reg();
            rb = rand_reg();
            rc = rand_reg();
            rd = rand_reg();
            r  = rand_bits(17);
            issue("forward", enc_i(r[11:0], r[16:12], f3_add_sub, ra));
            issue("forward", enc_r(f7_base, ra, ra, f3_add_sub, rb));
            issue("forward", enc_r(f7_base, rb, ra, f3_xor, rc));
            issue("forward", enc_r(f7_alt, rc, ra, f3_add_sub, rd));
        end

        r = rand_bits(20);
        issue("x0_write", enc_i(12'h7ff, 5'd3, f3_add_sub, 5'd0));
        issue("x0_write", enc_u(op_lui, r[19:0], 5'd0));
        issue("x0_write", enc_r(f7_base, 5'd0, 5'd0, f3_add_sub, 5'd5));
        issue("x0_write", enc_i(12'h000, 5'd0, f3_or, 5'd6));

        for (k = 0; k < n_ill; k++) begin
            r  = rand_bits(32);
            rd = rand_reg();
            case (k)
                0:       word = {r[31:12], rd, 7'b0000011}; // Load.
                1:       word = {r[31:12], rd, 7'b1100011}; // Branch.
                2:       word = enc_r(7'h01, r[24:20], r[19:15], r[14:12], rd);
                3:       word = enc_r(f7_alt, r[24:20], r[19:15], f3_sll, rd);
                4:       word = enc_i({f7_alt, r[24:20]}, r[19:15], f3_sll, rd);
                default: word = enc_i({7'h01, r[24:20]}, r[19:15], f3_srl_sra, rd);
            endcase
            issue("illegal", word);
            issue("illegal", enc_i(12'h000, rd, f3_add_sub, rand_reg())); // Target unchanged.
        end

        idle(6);
        if (rd_idx == wr_idx) begin
            $display("All checks passed");
            $finish;
        end else begin
            report_error("expected reports still missing at end of run");
        end
    end

endmodule

// File: rv32i_pipe_top.f
hw/rv32i_pkg.sv
hw/control_word.sv
hw/regfile.sv
hw/stage_reg.sv
hw/i_decode.sv
hw/alu_execute.sv
hw/rv32i_pipe_top.sv
dv/rv32i_pipe_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= rv32i_pipe_tb
FILELIST  ?= rv32i_pipe_top.f
LOG       ?= sim.log
BIN       := obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@rm -f $(LOG)
	-./$(BIN) | tee $(LOG)
	@grep -q "All checks passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
